// ==== design/wb_bus_pkg.sv ====
/* Shared bus defaults, controller phase type and field width helper
   for the Wishbone host subsystem */

`default_nettype none

package wb_bus_pkg;

    // Default geometry of the register space
    localparam int DEFAULT_DATA_W     = 32;
    localparam int DEFAULT_NUM_BANKS  = 4;
    localparam int DEFAULT_BANK_WORDS = 4;

    // Bank word i resets to this value times i
    localparam logic [DEFAULT_DATA_W-1:0] DEFAULT_INIT_PATTERN = 32'h12345678;

    // Controller phases, one pass per Wishbone cycle
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RESPOND = 2'd2,
        RELEASE = 2'd3
    } host_state_e;

    // Bits needed to index n items, at least one
    function automatic int field_w(input int n);
        int w;
        w = $clog2(n);
        if (w < 1) begin
            w = 1;
        end
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== design/wb_host_ctrl.sv ====
/* Wishbone cycle sequencer with access strobe, write qualification,
   ack/err generation and read data register */

`default_nettype none

module wb_host_ctrl #(
    parameter int DATA_W = wb_bus_pkg::DEFAULT_DATA_W
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic              addr_valid_i,
    input  wire logic [DATA_W-1:0] rd_word_i,
    output logic                   access_en_o,
    output logic                   wr_en_o,
    output logic [DATA_W-1:0]      wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o
);
    import wb_bus_pkg::*;

    host_state_e state;
    host_state_e state_nxt;

    // One-cycle strobe while in ACCESS
    assign access_en_o = (state == ACCESS);

    // Unmapped writes never reach a bank
    assign wr_en_o = access_en_o & wb_we_i & addr_valid_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wb_cyc_i && wb_stb_i) begin
                    state_nxt = ACCESS;
                end
            end
            ACCESS: begin
                state_nxt = RESPOND;
            end
            RESPOND: begin
                state_nxt = RELEASE;
            end
            RELEASE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Response flags and read data, registered on leaving RESPOND
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            case (state)
                RESPOND: begin
                    wb_ack_o <= addr_valid_i;
                    wb_err_o <= ~addr_valid_i;
                    // Bank word was captured one edge earlier
                    if (addr_valid_i && !wb_we_i) begin
                        wb_dat_o <= rd_word_i;
                    end
                end
                RELEASE: begin
                    // Completion phase drops the handshake
                    wb_ack_o <= 1'b0;
                    wb_err_o <= 1'b0;
                end
                default: begin
                    wb_ack_o <= 1'b0;
                    wb_err_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_addr_decoder.sv ====
/* Address decoder: word offset, one-hot bank select, mapped flag */

`default_nettype none

module wb_addr_decoder #(
    parameter int DATA_W     = wb_bus_pkg::DEFAULT_DATA_W,
    parameter int NUM_BANKS  = wb_bus_pkg::DEFAULT_NUM_BANKS,
    parameter int BANK_WORDS = wb_bus_pkg::DEFAULT_BANK_WORDS
) (
    input  wire logic [DATA_W-1:0]                          wb_adr_i,
    output logic [NUM_BANKS-1:0]                            bank_sel_o,
    output logic [wb_bus_pkg::field_w(BANK_WORDS)-1:0]      word_off_o,
    output logic                                            addr_valid_o
);
    import wb_bus_pkg::*;

    localparam int OFF_W = field_w(BANK_WORDS);
    localparam int SEL_W = field_w(NUM_BANKS);

    logic [SEL_W-1:0]  bank_idx;
    logic [DATA_W-1:0] upper_bits;

    // Field split, offset in the low bits
    assign word_off_o = wb_adr_i[OFF_W-1:0];
    assign bank_idx   = wb_adr_i[OFF_W +: SEL_W];
    assign upper_bits = wb_adr_i >> (OFF_W + SEL_W);

    // Also rejects indices past a non power of two geometry
    assign addr_valid_o = (upper_bits == '0) &&
                          (int'(bank_idx) < NUM_BANKS) &&
                          (int'(word_off_o) < BANK_WORDS);

    // One-hot select, all zero when unmapped
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_sel_o[i] = addr_valid_o && (int'(bank_idx) == i);
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_reg_bank.sv ====
/* Register bank: pattern-initialised words, write port, registered read */

`default_nettype none

module wb_reg_bank #(
    parameter int                DATA_W       = wb_bus_pkg::DEFAULT_DATA_W,
    parameter int                BANK_WORDS   = wb_bus_pkg::DEFAULT_BANK_WORDS,
    parameter logic [DATA_W-1:0] INIT_PATTERN = wb_bus_pkg::DEFAULT_INIT_PATTERN,
    parameter int                BANK_INDEX   = 0
) (
    input  wire logic                                       clk,
    input  wire logic                                       rst,
    input  wire logic                                       wr_en_i,
    input  wire logic                                       sel_i,
    input  wire logic [wb_bus_pkg::field_w(BANK_WORDS)-1:0] word_off_i,
    input  wire logic [DATA_W-1:0]                          wr_data_i,
    input  wire logic                                       access_en_i,
    output logic [DATA_W-1:0]                               rd_data_o
);

    logic [DATA_W-1:0] mem [BANK_WORDS];

    // Reset value follows the global word index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                mem[i] <= DATA_W'(INIT_PATTERN * (BANK_INDEX * BANK_WORDS + i));
            end
        end else if (wr_en_i && sel_i) begin
            mem[word_off_i] <= wr_data_i;
        end
    end

    // Read capture happens on the same edge as a write, so old data is seen
    always_ff @(posedge clk) begin
        if (access_en_i) begin
            rd_data_o <= mem[word_off_i];
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_read_mux.sv ====
/* AND-OR read multiplexer over the bank read words */

`default_nettype none

module wb_read_mux #(
    parameter int DATA_W    = wb_bus_pkg::DEFAULT_DATA_W,
    parameter int NUM_BANKS = wb_bus_pkg::DEFAULT_NUM_BANKS
) (
    input  wire logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rd_i,
    input  wire logic [NUM_BANKS-1:0]             bank_sel_i,
    output logic [DATA_W-1:0]                     rd_word_o
);

    // Select is one-hot or zero, so OR of masked words is enough
    always_comb begin
        rd_word_o = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            rd_word_o = rd_word_o | (bank_rd_i[i] & {DATA_W{bank_sel_i[i]}});
        end
    end

endmodule

`default_nettype wire

// ==== design/wb_host_top.sv ====
/* Wishbone host top: controller, decoder, bank array and read multiplexer */

`default_nettype none

module wb_host_top #(
    parameter int                DATA_W       = wb_bus_pkg::DEFAULT_DATA_W,
    parameter int                NUM_BANKS    = wb_bus_pkg::DEFAULT_NUM_BANKS,
    parameter int                BANK_WORDS   = wb_bus_pkg::DEFAULT_BANK_WORDS,
    parameter logic [DATA_W-1:0] INIT_PATTERN = wb_bus_pkg::DEFAULT_INIT_PATTERN
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [DATA_W-1:0] wb_adr_i,
    input  wire logic [DATA_W-1:0] wb_dat_i,
    output logic [DATA_W-1:0]      wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o
);
    import wb_bus_pkg::*;

    localparam int OFF_W = field_w(BANK_WORDS);

    logic [NUM_BANKS-1:0]             bank_sel;
    logic [OFF_W-1:0]                 word_off;
    logic                             addr_valid;
    logic                             access_en;
    logic                             wr_en;
    logic [DATA_W-1:0]                rd_word;
    logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rd;

    wb_host_ctrl #(
        .DATA_W (DATA_W)
    ) ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .addr_valid_i (addr_valid),
        .rd_word_i    (rd_word),
        .access_en_o  (access_en),
        .wr_en_o      (wr_en),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .wb_err_o     (wb_err_o)
    );

    wb_addr_decoder #(
        .DATA_W     (DATA_W),
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) dec_inst (
        .wb_adr_i     (wb_adr_i),
        .bank_sel_o   (bank_sel),
        .word_off_o   (word_off),
        .addr_valid_o (addr_valid)
    );

    // Each bank knows its index for the reset pattern
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        wb_reg_bank #(
            .DATA_W       (DATA_W),
            .BANK_WORDS   (BANK_WORDS),
            .INIT_PATTERN (INIT_PATTERN),
            .BANK_INDEX   (b)
        ) bank_inst (
            .clk         (clk),
            .rst         (rst),
            .wr_en_i     (wr_en),
            .sel_i       (bank_sel[b]),
            .word_off_i  (word_off),
            .wr_data_i   (wb_dat_i),
            .access_en_i (access_en),
            .rd_data_o   (bank_rd[b])
        );
    end

    wb_read_mux #(
        .DATA_W    (DATA_W),
        .NUM_BANKS (NUM_BANKS)
    ) mux_inst (
        .bank_rd_i  (bank_rd),
        .bank_sel_i (bank_sel),
        .rd_word_o  (rd_word)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_wb_host_top.sv ====
/* Testbench for the Wishbone host: master cycle tasks, reference memory model,
   assertion checks and final report */

`default_nettype none

module tb_wb_host_top;
    import wb_bus_pkg::*;

    localparam int DATA_W       = DEFAULT_DATA_W;
    localparam int NUM_WORDS    = DEFAULT_NUM_BANKS * DEFAULT_BANK_WORDS;
    localparam int IDX_W        = $clog2(NUM_WORDS);
    localparam int RESP_EDGES   = 3;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 300;
    // Three full readbacks, twelve directed cycles, then random traffic
    localparam int PLANNED_TX   = 3 * NUM_WORDS + 12 + NUM_RANDOM;
    // Four clocks per cycle, one more when stb drops in between
    localparam int MAX_CYCLES   = PLANNED_TX * 5 + RESET_CYCLES + 50;

    logic              clk;
    logic              rst;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [DATA_W-1:0] wb_adr_i;
    logic [DATA_W-1:0] wb_dat_i;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack_o;
    logic              wb_err_o;

    logic [DATA_W-1:0] model [NUM_WORDS];
    integer            seed;
    int                errors;
    int                cycles;
    string             test_name;

    wb_host_top wb_host_top_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o)
    );

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no end of test after %0d clock cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // Ack and err never together
    assert property (@(posedge clk) disable iff (rst) !(wb_ack_o && wb_err_o))
        else begin
            errors++;
            $display("Ack and err were high in the same cycle");
        end

    // A response lasts one cycle
    assert property (@(posedge clk) disable iff (rst)
                     (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o))
        else begin
            errors++;
            $display("Response stayed high for more than one cycle");
        end

    // One Wishbone cycle, edges counted from the accepting edge
    task automatic bus_cycle(input logic we, input logic [DATA_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input bit keep_stb,
                             output logic [DATA_W-1:0] rdata, output logic got_ack,
                             output logic got_err, output int edges);
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!wb_ack_o && !wb_err_o && edges < 8);
        got_ack = wb_ack_o;
        got_err = wb_err_o;
        rdata   = wb_dat_o;
        if (!keep_stb) begin
            @(posedge clk);
            wb_cyc_i <= 1'b0;
            wb_stb_i <= 1'b0;
        end
    endtask

    // Run a cycle and check it against the model
    task automatic check_access(input logic we, input logic [DATA_W-1:0] adr,
                                input logic [DATA_W-1:0] dat, input bit keep_stb);
        logic [DATA_W-1:0] rdata;
        logic              got_ack;
        logic              got_err;
        int                edges;
        bit                mapped;
        mapped = (adr < NUM_WORDS);
        bus_cycle(we, adr, dat, keep_stb, rdata, got_ack, got_err, edges);
        assert (got_ack || got_err) else begin
            errors++;
            $display("%s: no ack or err for address %h", test_name, adr);
        end
        assert (edges == RESP_EDGES) else begin
            errors++;
            $display("Error %s: expected latency %0d, actual %0d", test_name, RESP_EDGES, edges);
        end
        assert (got_ack == mapped && got_err == !mapped) else begin
            errors++;
            $display("Error %s: expected ack/err %b%b, actual %b%b",
                     test_name, mapped, !mapped, got_ack, got_err);
        end
        if (mapped && we) begin
            model[adr[IDX_W-1:0]] = dat;
        end else if (mapped) begin
            assert (rdata == model[adr[IDX_W-1:0]]) else begin
                errors++;
                $display("Error %s: expected %h, actual %h at %h",
                         test_name, model[adr[IDX_W-1:0]], rdata, adr);
            end
        end
    endtask

    task automatic read_all_words(input string name);
        test_name = name;
        for (int i = 0; i < NUM_WORDS; i++) begin
            check_access(1'b0, DATA_W'(i), '0, 1'b0);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] adr;
        int                shift;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        errors   = 0;
        cycles   = 0;
        seed     = 32'hfc89;
        for (int i = 0; i < NUM_WORDS; i++) begin
            model[i] = DEFAULT_INIT_PATTERN * i;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_name = "reset_state";
        assert (!wb_ack_o && !wb_err_o && wb_dat_o == '0) else begin
            errors++;
            $display("Error %s: expected 0 0 %h, actual %b %b %h",
                     test_name, '0, wb_ack_o, wb_err_o, wb_dat_o);
        end
        read_all_words("reset_readback");

        test_name = "write_read";
        for (int i = 0; i < 4; i++) begin
            adr = DATA_W'(i * 5);
            check_access(1'b1, adr, $random(seed), 1'b0);
            check_access(1'b0, adr, '0, 1'b0);
        end
        read_all_words("write_readback");

        test_name = "unmapped";
        check_access(1'b1, 32'h0000_0010, 32'hdead_beef, 1'b0);
        check_access(1'b1, 32'h8000_0005, 32'hcafe_f00d, 1'b0);
        check_access(1'b0, 32'h0000_0103, '0, 1'b0);
        check_access(1'b0, 32'h0001_000f, '0, 1'b0);
        read_all_words("unmapped_readback");

        // Back-to-back traffic, stb sometimes held across cycles
        test_name = "random_traffic";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            adr = DATA_W'($unsigned($random(seed)) % NUM_WORDS);
            if (($random(seed) & 7) == 0) begin
                shift = IDX_W + ($unsigned($random(seed)) % (DATA_W - IDX_W));
                adr   = adr | (DATA_W'(1) << shift);
            end
            check_access($random(seed) & 1, adr, $random(seed),
                         (i != NUM_RANDOM - 1) && ($random(seed) & 1));
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/wb_bus_pkg.sv
design/wb_host_ctrl.sv
design/wb_addr_decoder.sv
design/wb_reg_bank.sv
design/wb_read_mux.sv
design/wb_host_top.sv
testbench/tb_wb_host_top.sv

// ==== Bender.yml ====
package:
  name: wb_host

sources:
  - design/wb_bus_pkg.sv
  - design/wb_host_ctrl.sv
  - design/wb_addr_decoder.sv
  - design/wb_reg_bank.sv
  - design/wb_read_mux.sv
  - design/wb_host_top.sv
  - target: simulation
    files:
      - testbench/tb_wb_host_top.sv
